// File: rv_pipe.f
+incdir+hdl
hdl/rv_pipe_pkg.sv
hdl/rv_fetch.sv
hdl/rv_regfile.sv
hdl/rv_decode.sv
hdl/rv_execute.sv
hdl/rv_retire.sv
hdl/rv_pipe.sv
dv/rv_pipe_tb.sv

// File: dv/rv_pipe_tb.sv
// rv_pipe testbench
// random rv32i programs run against an instruction-set model,
// commit beats checked by concurrent assertions

`include "rv_pipe_cfg.svh"

module rv_pipe_tb;
    import rv_pipe_pkg::*;

    localparam int prog_words = 256;
    localparam logic [31:0] wfi_word = 32'h1050_0073;

    logic         clk;
    logic         rst;
    word_t        imem_addr;
    word_t        imem_data;
    commit_t      commit;
    pipe_status_e status;
    word_t        retire_count;

    logic [31:0]  prog [prog_words];

    // expected commit sequence from the model
    logic [31:0]  exp_pc [prog_words];
    logic [4:0]   exp_rd [prog_words];
    logic [31:0]  exp_data [prog_words];
    logic         exp_wr [prog_words];
    logic [31:0]  exp_regs [32];
    pipe_status_e exp_status;
    int           exp_n;

    int           commit_idx;
    int           errors;
    int           timeouts;
    logic [31:0]  lcg_state;

    // combinational instruction memory
    assign imem_data = prog[imem_addr[9:2]];

    rv_pipe UUT (
        .clk          (clk),
        .rst          (rst),
        .imem_addr    (imem_addr),
        .imem_data    (imem_data),
        .commit       (commit),
        .status       (status),
        .retire_count (retire_count)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // index of the next expected commit
    always @(posedge clk) begin
        if (rst) begin
            commit_idx <= 0;
        end else if (commit.valid) begin
            commit_idx <= commit_idx + 1;
        end
    end

    ////////////////////////////////////////////////////////////
    // helpers
    ////////////////////////////////////////////////////////////

    function automatic logic [31:0] next_random();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        // fold high bits down since low lcg bits repeat quickly
        return lcg_state ^ (lcg_state >> 15);
    endfunction

    function automatic logic [31:0] r_type_word(logic [6:0] f7, logic [2:0] f3,
                                                logic [4:0] rd, logic [4:0] rs1,
                                                logic [4:0] rs2);
        return {f7, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    function automatic logic [31:0] i_type_word(logic [11:0] imm, logic [2:0] f3,
                                                logic [4:0] rd, logic [4:0] rs1);
        return {imm, rs1, f3, rd, 7'b0010011};
    endfunction

    function automatic logic [31:0] branch_word(logic [12:0] off, logic [2:0] f3,
                                                logic [4:0] rs1, logic [4:0] rs2);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], 7'b1100011};
    endfunction

    task automatic show_mismatch(input string name, input logic [31:0] got,
                                 input logic [31:0] want);
        errors++;
        $display("Error: %s got %h expected %h", name, got, want);
    endtask

    task automatic fill_memory();
        for (int a = 0; a < prog_words; a++) begin
            // illegal opcode zero with the address in the upper bits
            prog[a] = {a[24:0], 7'b0000000};
        end
    endtask

    ////////////////////////////////////////////////////////////
    // programs
    ////////////////////////////////////////////////////////////

    task automatic build_alu_program();
        logic [31:0] r;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [4:0]  prev_rd;
        logic [4:0]  prev2_rd;
        logic [6:0]  f7;
        logic [2:0]  f3;
        int          n;
        fill_memory();
        // x1..x7 get random signed values
        for (n = 0; n < 7; n++) begin
            r = next_random();
            prog[n] = i_type_word(r[11:0], 3'b000, 5'(n + 1), 5'd0);
        end
        // beq always taken and skips two words
        prog[7]  = branch_word(13'd12, 3'b000, 5'd1, 5'd1);
        prog[8]  = i_type_word(12'h7ff, 3'b000, 5'd1, 5'd0);
        prog[9]  = i_type_word(12'h7ff, 3'b000, 5'd2, 5'd0);
        // bne never taken so it falls through
        prog[10] = branch_word(13'd12, 3'b001, 5'd3, 5'd3);
        n = 11;
        prev_rd  = 5'd1;
        prev2_rd = 5'd2;
        for (int k = 0; k < 48; k++) begin
            r  = next_random();
            // small register pool with x0 so neighbours collide
            rd = {2'b00, r[2:0]};
            case (r[4:3])
                2'd0:    rs1 = prev_rd;
                2'd1:    rs1 = prev2_rd;
                default: rs1 = {2'b00, r[7:5]};
            endcase
            rs2 = r[9] ? prev_rd : {2'b00, r[12:10]};
            if (r[15:13] == 3'd6 && k < 45) begin
                // forward over one or two words with the target in the stream
                prog[n] = branch_word(r[16] ? 13'd12 : 13'd8, {2'b00, r[17]}, rs1, rs2);
            end else if (r[15]) begin
                case (r[29:28])
                    2'd0:    f3 = 3'b000;
                    2'd1:    f3 = 3'b111;
                    2'd2:    f3 = 3'b110;
                    default: f3 = 3'b100;
                endcase
                prog[n] = i_type_word(r[27:16], f3, rd, rs1);
            end else begin
                f7 = 7'h00;
                case (r[18:16])
                    3'd0:    f3 = 3'b000;
                    3'd1:    f3 = 3'b111;
                    3'd2:    f3 = 3'b110;
                    3'd3:    f3 = 3'b100;
                    3'd4:    f3 = 3'b010;
                    default: begin
                        f7 = 7'h20;
                        f3 = 3'b000;
                    end
                endcase
                prog[n] = r_type_word(f7, f3, rd, rs1, rs2);
            end
            prev2_rd = prev_rd;
            prev_rd  = rd;
            n++;
        end
        prog[n] = wfi_word;
    endtask

    task automatic build_illegal_program();
        fill_memory();
        prog[0] = i_type_word(12'h123, 3'b000, 5'd1, 5'd0);
        prog[1] = r_type_word(7'h00, 3'b000, 5'd2, 5'd1, 5'd1);
        // slli is outside the subset
        prog[2] = i_type_word(12'd1, 3'b001, 5'd1, 5'd1);
        prog[3] = i_type_word(12'd1, 3'b000, 5'd3, 5'd2);
        prog[4] = wfi_word;
    endtask

    ////////////////////////////////////////////////////////////
    // instruction-set model
    ////////////////////////////////////////////////////////////

    task automatic run_model();
        logic [31:0] pc;
        logic [31:0] w;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] imm;
        logic [31:0] res;
        logic        legal;
        logic        wr;
        logic        taken;
        logic        done;
        for (int k = 0; k < 32; k++) begin
            exp_regs[k] = '0;
        end
        pc         = `RESET_PC;
        exp_n      = 0;
        done       = 1'b0;
        exp_status = no_error;
        while (!done && exp_n < prog_words) begin
            w     = prog[pc[9:2]];
            a     = exp_regs[w[19:15]];
            b     = exp_regs[w[24:20]];
            imm   = {{20{w[31]}}, w[31:20]};
            res   = '0;
            wr    = 1'b0;
            legal = 1'b1;
            taken = 1'b0;
            case (w[6:0])
                7'h33: begin
                    wr = 1'b1;
                    case ({w[31:25], w[14:12]})
                        10'h000: res = a + b;
                        10'h100: res = a - b;
                        10'h007: res = a & b;
                        10'h006: res = a | b;
                        10'h004: res = a ^ b;
                        10'h002: res = {31'b0, $signed(a) < $signed(b)};
                        default: legal = 1'b0;
                    endcase
                end
                7'h13: begin
                    wr = 1'b1;
                    case (w[14:12])
                        3'b000:  res = a + imm;
                        3'b111:  res = a & imm;
                        3'b110:  res = a | imm;
                        3'b100:  res = a ^ imm;
                        default: legal = 1'b0;
                    endcase
                end
                7'h63: begin
                    legal = (w[14:13] == 2'b00);
                    // funct3 bit 0 picks bne
                    taken = (a == b) ^ w[12];
                end
                7'h73:   legal = (w == wfi_word);
                default: legal = 1'b0;
            endcase
            wr = wr & legal;
            exp_pc[exp_n]   = pc;
            exp_rd[exp_n]   = w[11:7];
            exp_data[exp_n] = res;
            exp_wr[exp_n]   = wr;
            exp_n++;
            if (wr && w[11:7] != 5'd0) begin
                exp_regs[w[11:7]] = res;
            end
            if (!legal) begin
                exp_status = illegal_inst;
                done       = 1'b1;
            end else if (w[6:0] == 7'h73) begin
                exp_status = halted_on_wfi;
                done       = 1'b1;
            end else if (taken) begin
                pc = pc + {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
            end else begin
                pc = pc + 32'd4;
            end
        end
    endtask

    ////////////////////////////////////////////////////////////
    // commit checks
    ////////////////////////////////////////////////////////////

    assert property (@(posedge clk) disable iff (rst)
        commit.valid |-> (commit_idx < exp_n))
    else begin
        errors++;
        $display("commit at pc %h arrived after the model had stopped", $sampled(commit.pc));
    end

    assert property (@(posedge clk) disable iff (rst)
        (commit.valid && commit_idx < exp_n) |-> (commit.pc == exp_pc[commit_idx]))
    else show_mismatch("commit.pc", $sampled(commit.pc), exp_pc[$sampled(commit_idx)]);

    assert property (@(posedge clk) disable iff (rst)
        (commit.valid && commit_idx < exp_n) |-> (commit.writes_rd == exp_wr[commit_idx]))
    else show_mismatch("commit.writes_rd", $sampled(commit.writes_rd),
                       exp_wr[$sampled(commit_idx)]);

    assert property (@(posedge clk) disable iff (rst)
        (commit.valid && commit_idx < exp_n && exp_wr[commit_idx])
        |-> (commit.rd == exp_rd[commit_idx]))
    else show_mismatch("commit.rd", $sampled(commit.rd), exp_rd[$sampled(commit_idx)]);

    assert property (@(posedge clk) disable iff (rst)
        (commit.valid && commit_idx < exp_n && exp_wr[commit_idx])
        |-> (commit.data == exp_data[commit_idx]))
    else show_mismatch("commit.data", $sampled(commit.data), exp_data[$sampled(commit_idx)]);

    // status moves only in the cycle after the last commit
    assert property (@(posedge clk) disable iff (rst)
        (commit.valid && commit_idx < exp_n - 1) |=> (status == no_error))
    else show_mismatch("status", $sampled(status), no_error);

    assert property (@(posedge clk) disable iff (rst)
        (commit.valid && commit_idx == exp_n - 1) |=> (status == exp_status))
    else show_mismatch("status", $sampled(status), exp_status);

    task automatic check_reset_outputs();
        assert (commit.valid == 1'b0)
            else show_mismatch("commit.valid", commit.valid, 1'b0);
        assert (status == no_error)
            else show_mismatch("status", status, no_error);
        assert (retire_count == '0)
            else show_mismatch("retire_count", retire_count, '0);
        assert (imem_addr == `RESET_PC)
            else show_mismatch("imem_addr", imem_addr, `RESET_PC);
    endtask

    task automatic check_end_state();
        assert (status == exp_status)
            else show_mismatch("status", status, exp_status);
        assert (retire_count == exp_n)
            else show_mismatch("retire_count", retire_count, exp_n);
        for (int k = 0; k < 32; k++) begin
            assert (UUT.u_regfile.regs[k] == exp_regs[k])
                else show_mismatch($sformatf("u_regfile.regs[%0d]", k),
                                   UUT.u_regfile.regs[k], exp_regs[k]);
        end
    endtask

    task automatic wait_for_stop(input int limit);
        int cyc;
        cyc = 0;
        while (status == no_error && cyc < limit) begin
            @(negedge clk);
            cyc++;
        end
        if (status == no_error) begin
            timeouts++;
            $display("core did not stop within %0d cycles", limit);
        end
    endtask

    ////////////////////////////////////////////////////////////
    // main sequence
    ////////////////////////////////////////////////////////////

    initial begin
        errors    = 0;
        timeouts  = 0;
        lcg_state = 32'hb5d;
        rst       = 1'b1;

        // alu stream with branches ending on wfi
        build_alu_program();
        run_model();
        repeat (10) @(negedge clk);
        check_reset_outputs();
        rst = 1'b0;
        wait_for_stop(400);
        // halted core stays quiet for 20 cycles
        repeat (20) @(negedge clk);
        check_end_state();

        // second reset with an illegal word mid program
        rst = 1'b1;
        build_illegal_program();
        run_model();
        repeat (10) @(negedge clk);
        check_reset_outputs();
        rst = 1'b0;
        wait_for_stop(100);
        repeat (20) @(negedge clk);
        check_end_state();

        $display("errors: %0d check failures, %0d timeouts", errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

// File: hdl/rv_pipe.sv
// rv_pipe
// four-stage rv32i integer core: fetch, decode, execute, retire

module rv_pipe (
    input  logic                      clk,
    input  logic                      rst,
    output rv_pipe_pkg::word_t        imem_addr,
    input  rv_pipe_pkg::word_t        imem_data,
    output rv_pipe_pkg::commit_t      commit,
    output rv_pipe_pkg::pipe_status_e status,
    output rv_pipe_pkg::word_t        retire_count
);
    import rv_pipe_pkg::*;

    // stage packets
    if_id_t    if_id;
    id_ex_t    id_ex;
    ex_wb_t    ex_wb;
    redirect_t redirect;

    // register file read ports
    reg_idx_t  rs1_idx;
    reg_idx_t  rs2_idx;
    word_t     rs1_val;
    word_t     rs2_val;

    ////////////////////////////////////////////////////////////
    // stages
    ////////////////////////////////////////////////////////////

    rv_fetch u_fetch (
        .clk       (clk),
        .rst       (rst),
        .imem_addr (imem_addr),
        .imem_data (imem_data),
        .redirect  (redirect),
        .if_id     (if_id)
    );

    // write port is the commit packet
    rv_regfile u_regfile (
        .clk     (clk),
        .rst     (rst),
        .rs1_idx (rs1_idx),
        .rs2_idx (rs2_idx),
        .rs1_val (rs1_val),
        .rs2_val (rs2_val),
        .wr      (commit)
    );

    rv_decode u_decode (
        .clk      (clk),
        .rst      (rst),
        .if_id    (if_id),
        .redirect (redirect),
        .rs1_idx  (rs1_idx),
        .rs2_idx  (rs2_idx),
        .rs1_val  (rs1_val),
        .rs2_val  (rs2_val),
        .id_ex    (id_ex)
    );

    rv_execute u_execute (
        .clk      (clk),
        .rst      (rst),
        .id_ex    (id_ex),
        .redirect (redirect),
        .ex_wb    (ex_wb)
    );

    rv_retire u_retire (
        .clk          (clk),
        .rst          (rst),
        .ex_wb        (ex_wb),
        .commit       (commit),
        .status       (status),
        .retire_count (retire_count)
    );

endmodule

// File: hdl/rv_retire.sv
// rv_retire
// commit port and register write, run/halt/fault status,
// retired instruction count

module rv_retire (
    input  logic                      clk,
    input  logic                      rst,
    input  rv_pipe_pkg::ex_wb_t       ex_wb,
    output rv_pipe_pkg::commit_t      commit,
    output rv_pipe_pkg::pipe_status_e status,
    output rv_pipe_pkg::word_t        retire_count
);
    import rv_pipe_pkg::*;

    pipe_status_e status_q;
    word_t        count_q;

    // same packet feeds the regfile write port
    assign commit = '{valid:     ex_wb.valid,
                      pc:        ex_wb.pc,
                      rd:        ex_wb.rd,
                      data:      ex_wb.result,
                      writes_rd: ex_wb.writes_rd};

    // no_error is the running state
    // leaves it once, then holds until reset
    always_ff @(posedge clk) begin
        if (rst) begin
            status_q <= no_error;
        end else if (status_q == no_error && ex_wb.valid) begin
            if (ex_wb.illegal) begin
                status_q <= illegal_inst;
            end else if (ex_wb.is_wfi) begin
                status_q <= halted_on_wfi;
            end
        end
    end

    // one per commit beat
    always_ff @(posedge clk) begin
        if (rst) begin
            count_q <= '0;
        end else if (commit.valid) begin
            count_q <= count_q + word_t'(1);
        end
    end

    assign status       = status_q;
    assign retire_count = count_q;

endmodule

// File: hdl/rv_execute.sv
// rv_execute
// forwarding from the retire entry, alu, beq/bne resolution,
// stop on wfi or illegal, and the execute/retire register

module rv_execute (
    input  logic                   clk,
    input  logic                   rst,
    input  rv_pipe_pkg::id_ex_t    id_ex,
    output rv_pipe_pkg::redirect_t redirect,
    output rv_pipe_pkg::ex_wb_t    ex_wb
);
    import rv_pipe_pkg::*;

    word_t  op_a;
    word_t  op_b_reg;
    word_t  op_b;
    word_t  alu_res;
    logic   equal;
    ex_wb_t ex_wb_d;

    ////////////////////////////////////////////////////////////
    // operand forwarding
    ////////////////////////////////////////////////////////////

    // older instruction sits in ex_wb this cycle
    // distance two is covered by regfile write-through
    function automatic word_t forward(reg_idx_t idx, word_t reg_val, ex_wb_t older);
        if (older.valid && older.writes_rd && (older.rd != '0) && (older.rd == idx)) begin
            return older.result;
        end
        return reg_val;
    endfunction

    assign op_a     = forward(id_ex.rs1, id_ex.rs1_val, ex_wb);
    assign op_b_reg = forward(id_ex.rs2, id_ex.rs2_val, ex_wb);
    assign op_b     = id_ex.use_imm ? id_ex.imm : op_b_reg;

    ////////////////////////////////////////////////////////////
    // alu
    ////////////////////////////////////////////////////////////

    always_comb begin
        case (id_ex.alu_op)
            alu_sub: alu_res = op_a - op_b;
            alu_and: alu_res = op_a & op_b;
            alu_or:  alu_res = op_a | op_b;
            alu_xor: alu_res = op_a ^ op_b;
            // signed compare
            alu_slt: alu_res = word_t'($signed(op_a) < $signed(op_b));
            default: alu_res = op_a + op_b;
        endcase
    end

    // branch compare always on the two registers
    assign equal = (op_a == op_b_reg);

    // beq takes on equal, bne on not equal
    assign redirect.take   = id_ex.valid & id_ex.is_branch
                           & (equal == id_ex.branch_on_equal);
    assign redirect.target = id_ex.pc + id_ex.imm;
    assign redirect.stop   = id_ex.valid & (id_ex.is_wfi | id_ex.illegal);

    always_comb begin
        ex_wb_d.valid     = id_ex.valid;
        ex_wb_d.pc        = id_ex.pc;
        ex_wb_d.rd        = id_ex.rd;
        ex_wb_d.result    = alu_res;
        // branches, wfi and illegal words leave the register file alone
        ex_wb_d.writes_rd = ~(id_ex.is_branch | id_ex.is_wfi | id_ex.illegal);
        ex_wb_d.is_wfi    = id_ex.is_wfi;
        ex_wb_d.illegal   = id_ex.illegal;
    end

    // execute/retire register
    always_ff @(posedge clk) begin
        ex_wb <= ex_wb_d;
        if (rst) begin
            ex_wb.valid <= 1'b0;
        end
    end

endmodule

// File: hdl/rv_decode.sv
// rv_decode
// decodes the rv32i subset, builds immediates, reads the register
// file and loads the decode/execute register

module rv_decode (
    input  logic                   clk,
    input  logic                   rst,
    input  rv_pipe_pkg::if_id_t    if_id,
    input  rv_pipe_pkg::redirect_t redirect,
    output rv_pipe_pkg::reg_idx_t  rs1_idx,
    output rv_pipe_pkg::reg_idx_t  rs2_idx,
    input  rv_pipe_pkg::word_t     rs1_val,
    input  rv_pipe_pkg::word_t     rs2_val,
    output rv_pipe_pkg::id_ex_t    id_ex
);
    import rv_pipe_pkg::*;

    // funct12 of wfi, all other fields zero
    localparam logic [11:0] wfi_funct12 = 12'h105;

    inst_u  inst;
    word_t  imm_i;
    word_t  imm_b;
    logic   is_wfi_word;
    id_ex_t id_ex_d;

    assign inst = if_id.inst;

    // register reads straight from the word, unused fields are harmless
    assign rs1_idx = inst.r.rs1;
    assign rs2_idx = inst.r.rs2;

    ////////////////////////////////////////////////////////////
    // immediates
    ////////////////////////////////////////////////////////////

    assign imm_i = {{($bits(word_t) - 12){inst.i.imm[11]}}, inst.i.imm};

    // b-type: imm[12|10:5] in funct7, imm[4:1|11] in rd
    assign imm_b = {{($bits(word_t) - 13){inst.r.funct7[6]}},
                    inst.r.funct7[6],
                    inst.r.rd[0],
                    inst.r.funct7[5:0],
                    inst.r.rd[4:1],
                    1'b0};

    assign is_wfi_word = (inst.i.imm == wfi_funct12) && (inst.i.rs1 == '0)
                      && (inst.i.funct3 == 3'b000) && (inst.i.rd == '0);

    ////////////////////////////////////////////////////////////
    // control decode
    ////////////////////////////////////////////////////////////

    always_comb begin
        id_ex_d         = '0;
        id_ex_d.valid   = if_id.valid;
        id_ex_d.pc      = if_id.pc;
        id_ex_d.rs1     = inst.r.rs1;
        id_ex_d.rs2     = inst.r.rs2;
        id_ex_d.rd      = inst.r.rd;
        id_ex_d.rs1_val = rs1_val;
        id_ex_d.rs2_val = rs2_val;
        id_ex_d.imm     = imm_i;
        id_ex_d.alu_op  = alu_add;

        case (inst.r.opcode)
            op_reg: begin
                // funct7 and funct3 together
                case ({inst.r.funct7, inst.r.funct3})
                    10'b0000000_000: id_ex_d.alu_op = alu_add;
                    10'b0100000_000: id_ex_d.alu_op = alu_sub;
                    10'b0000000_111: id_ex_d.alu_op = alu_and;
                    10'b0000000_110: id_ex_d.alu_op = alu_or;
                    10'b0000000_100: id_ex_d.alu_op = alu_xor;
                    10'b0000000_010: id_ex_d.alu_op = alu_slt;
                    default:         id_ex_d.illegal = 1'b1;
                endcase
            end
            op_imm: begin
                id_ex_d.use_imm = 1'b1;
                case (inst.i.funct3)
                    3'b000:  id_ex_d.alu_op = alu_add;
                    3'b111:  id_ex_d.alu_op = alu_and;
                    3'b110:  id_ex_d.alu_op = alu_or;
                    3'b100:  id_ex_d.alu_op = alu_xor;
                    // slti and shifts are outside the subset
                    default: id_ex_d.illegal = 1'b1;
                endcase
            end
            op_branch: begin
                id_ex_d.is_branch = 1'b1;
                id_ex_d.imm       = imm_b;
                case (inst.r.funct3)
                    3'b000:  id_ex_d.branch_on_equal = 1'b1;
                    3'b001:  id_ex_d.branch_on_equal = 1'b0;
                    default: id_ex_d.illegal = 1'b1;
                endcase
            end
            op_system: begin
                // only wfi, no csr access
                if (is_wfi_word) begin
                    id_ex_d.is_wfi = 1'b1;
                end else begin
                    id_ex_d.illegal = 1'b1;
                end
            end
            default: id_ex_d.illegal = 1'b1;
        endcase
    end

    // decode/execute register, redirect kills the entry
    always_ff @(posedge clk) begin
        id_ex <= id_ex_d;
        if (rst || redirect.take || redirect.stop) begin
            id_ex.valid <= 1'b0;
        end
    end

endmodule

// File: hdl/rv_regfile.sv
// rv_regfile
// 32 x XLEN register file, x0 reads as zero,
// same-cycle write is returned on the read ports

module rv_regfile (
    input  logic                  clk,
    input  logic                  rst,
    input  rv_pipe_pkg::reg_idx_t rs1_idx,
    input  rv_pipe_pkg::reg_idx_t rs2_idx,
    output rv_pipe_pkg::word_t    rs1_val,
    output rv_pipe_pkg::word_t    rs2_val,
    input  rv_pipe_pkg::commit_t  wr
);
    import rv_pipe_pkg::*;

    word_t regs [2**$bits(reg_idx_t)];
    logic  wr_en;

    // x0 never written so it keeps its reset zero
    assign wr_en = wr.valid & wr.writes_rd & (wr.rd != '0);

    // one read port with bypass from the retire write
    function automatic word_t read_port(reg_idx_t idx);
        if (wr_en && (wr.rd == idx)) begin
            return wr.data;
        end
        return regs[idx];
    endfunction

    always_comb begin
        rs1_val = read_port(rs1_idx);
        rs2_val = read_port(rs2_idx);
    end

    // all registers clear on reset
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < 2**$bits(reg_idx_t); i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en) begin
            regs[wr.rd] <= wr.data;
        end
    end

endmodule

// File: hdl/rv_fetch.sv
// rv_fetch
// program counter with branch redirect and a permanent stop,
// plus the fetch/decode register

`include "rv_pipe_cfg.svh"

module rv_fetch (
    input  logic                   clk,
    input  logic                   rst,
    output logic [`XLEN-1:0]       imem_addr,
    input  logic [`XLEN-1:0]       imem_data,
    input  rv_pipe_pkg::redirect_t redirect,
    output rv_pipe_pkg::if_id_t    if_id
);
    import rv_pipe_pkg::*;

    word_t pc;
    logic  stopped;
    logic  flush;
    logic  running;

    // branch or stop kills the word fetched this cycle
    assign flush = redirect.take | redirect.stop;
    assign running = ~stopped & ~flush;

    // memory answers within the cycle
    assign imem_addr = pc;

    // pc and stop flag
    always_ff @(posedge clk) begin
        if (rst) begin
            pc      <= `RESET_PC;
            stopped <= 1'b0;
        end else if (redirect.stop) begin
            // wfi or illegal in execute, hold until reset
            stopped <= 1'b1;
        end else if (redirect.take) begin
            pc <= redirect.target;
        end else if (!stopped) begin
            pc <= pc + word_t'(4);
        end
    end

    // fetch/decode register
    always_ff @(posedge clk) begin
        if (rst) begin
            if_id.valid <= 1'b0;
            if_id.inst  <= `NOP_INST;
        end else begin
            if_id.valid <= running;
            // bubble word when stopped or flushed
            if_id.inst  <= running ? imem_data : `NOP_INST;
        end
        if_id.pc <= pc;
    end

endmodule

// File: hdl/rv_pipe_pkg.sv
// rv_pipe shared types
// opcode and alu encodings, instruction word views,
// stage packets and the status code

`include "rv_pipe_cfg.svh"

package rv_pipe_pkg;

    typedef logic [`XLEN-1:0] word_t;
    typedef logic [$clog2(`REG_COUNT)-1:0] reg_idx_t;

    // major opcodes of the supported subset
    typedef enum logic [6:0] {
        op_reg    = 7'b0110011,
        op_imm    = 7'b0010011,
        op_branch = 7'b1100011,
        op_system = 7'b1110011
    } opcode_e;

    typedef enum logic [2:0] {
        alu_add,
        alu_sub,
        alu_and,
        alu_or,
        alu_xor,
        alu_slt
    } alu_op_e;

    ////////////////////////////////////////////////////////////
    // instruction word, register and immediate views
    ////////////////////////////////////////////////////////////

    typedef struct packed {
        logic [6:0] funct7;
        reg_idx_t   rs2;
        reg_idx_t   rs1;
        logic [2:0] funct3;
        reg_idx_t   rd;
        opcode_e    opcode;
    } inst_r_t;

    typedef struct packed {
        logic [11:0] imm;
        reg_idx_t    rs1;
        logic [2:0]  funct3;
        reg_idx_t    rd;
        opcode_e     opcode;
    } inst_i_t;

    // branch offset is spread over the funct7 and rd fields of the r view
    typedef union packed {
        inst_r_t r;
        inst_i_t i;
    } inst_u;

    ////////////////////////////////////////////////////////////
    // stage packets
    ////////////////////////////////////////////////////////////

    typedef struct packed {
        logic  valid;
        word_t pc;
        inst_u inst;
    } if_id_t;

    typedef struct packed {
        logic     valid;
        word_t    pc;
        reg_idx_t rs1;
        reg_idx_t rs2;
        reg_idx_t rd;
        word_t    rs1_val;
        word_t    rs2_val;
        word_t    imm;
        logic     use_imm;
        alu_op_e  alu_op;
        logic     is_branch;
        logic     branch_on_equal;
        logic     is_wfi;
        logic     illegal;
    } id_ex_t;

    typedef struct packed {
        logic     valid;
        word_t    pc;
        reg_idx_t rd;
        word_t    result;
        logic     writes_rd;
        logic     is_wfi;
        logic     illegal;
    } ex_wb_t;

    // execute back to fetch and decode
    typedef struct packed {
        logic  take;
        word_t target;
        logic  stop;
    } redirect_t;

    typedef struct packed {
        logic     valid;
        word_t    pc;
        reg_idx_t rd;
        word_t    data;
        logic     writes_rd;
    } commit_t;

    typedef enum logic [1:0] {
        no_error,
        halted_on_wfi,
        illegal_inst
    } pipe_status_e;

endpackage

// File: hdl/rv_pipe_cfg.svh
// rv_pipe configuration
// widths, reset fetch address and the bubble instruction word

`ifndef RV_PIPE_CFG_SVH
`define RV_PIPE_CFG_SVH

// data and address width
`define XLEN 32

// architectural registers, x0 included
`define REG_COUNT 32

// first fetch address after reset
`define RESET_PC 32'h0000_0000

// addi x0, x0, 0
// fills the fetch register while it holds no instruction
`define NOP_INST 32'h0000_0013

`endif
